//--- hw/vdma_pkg.sv
// shared widths and bundles; one pixel is one 32-bit word, and arlen+1 must not exceed fifo_depth
package vdma_pkg;

	// ----------------------------------------
	// widths
	localparam int addr_w   = 32;	// byte address
	localparam int data_w   = 32;	// one pixel per beat
	localparam int len_w    = 8;	// beats minus one
	localparam int stride_w = 14;
	localparam int h_w      = 12;
	localparam int v_w      = 12;
	localparam int index_w  = 8;

	// beat buffer sizing, also the credit pool
	localparam int fifo_depth = 64;
	localparam int credit_w   = 7;	// holds 0..fifo_depth

	// ----------------------------------------
	// bundles
	typedef struct packed {
		logic [addr_w-1:0]   base;	// first pixel of line 0
		logic [stride_w-1:0] stride;	// bytes between line starts
		logic [h_w-1:0]      width;	// pixels per line
		logic [v_w-1:0]      height;	// lines per frame
		logic [len_w-1:0]    arlen;	// max burst, beats minus one
	} frame_param_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [len_w-1:0]  len;
	} ar_req_t;

	typedef struct packed {
		logic [data_w-1:0] data;
	} r_beat_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic              sof;	// first pixel of frame
		logic              eol;	// last pixel of line
	} pix_beat_t;

endpackage

//--- hw/vdma_frame_ctrl.sv
// enable is ignored while busy; shadow registers load only on enable with update
`timescale 1ns/1ns

module vdma_frame_ctrl (
	input  logic                            aclk,
	input  logic                            aresetn,
	input  logic                            ctl_enable,
	input  logic                            ctl_update,
	input  vdma_pkg::frame_param_t          frame_param,
	output logic                            ctl_busy,
	output logic [vdma_pkg::index_w-1:0]    ctl_index,
	output vdma_pkg::frame_param_t          shadow_param,
	output logic                            frame_start,
	input  logic                            ag_done,
	input  logic                            fr_done
);

	logic                         busy_q;
	logic                         ag_seen;	// address side finished
	logic                         fr_seen;	// stream side finished
	logic                         start_q;
	logic [vdma_pkg::index_w-1:0] index_q;
	vdma_pkg::frame_param_t       shadow_q;

	logic start_now;
	logic both_done;

	assign start_now = !busy_q && ctl_enable;
	// a done pulse in this cycle counts as seen
	assign both_done = (ag_seen || ag_done) && (fr_seen || fr_done);

	// ----------------------------------------
	// idle/busy state and index
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			busy_q  <= 1'b0;
			ag_seen <= 1'b0;
			fr_seen <= 1'b0;
			start_q <= 1'b0;
			index_q <= '0;
		end else begin
			start_q <= start_now;
			if (start_now) begin
				busy_q  <= 1'b1;
				ag_seen <= 1'b0;
				fr_seen <= 1'b0;
				index_q <= index_q + 1'b1;	// host sees the frame was taken
			end else if (busy_q) begin
				if (both_done) begin
					busy_q  <= 1'b0;
					ag_seen <= 1'b0;
					fr_seen <= 1'b0;
				end else begin
					ag_seen <= ag_seen || ag_done;
					fr_seen <= fr_seen || fr_done;
				end
			end
		end
	end

	// shadow copy, workers read it from frame_start on
	always_ff @(posedge aclk) begin
		if (start_now && ctl_update) begin
			shadow_q <= frame_param;
		end
	end

	assign ctl_busy     = busy_q;
	assign ctl_index    = index_q;
	assign shadow_param = shadow_q;
	assign frame_start  = start_q;

endmodule

//--- hw/vdma_addr_gen.sv
// INCR bursts per line; a burst is raised only with credits for all its beats, width and height nonzero
`timescale 1ns/1ns

module vdma_addr_gen (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  vdma_pkg::frame_param_t param,
	input  logic                   frame_start,
	output vdma_pkg::ar_req_t      ar,
	output logic                   ar_valid,
	input  logic                   ar_ready,
	input  logic                   credit_return,
	output logic                   done
);

	logic                          active;
	logic                          done_q;
	logic [vdma_pkg::addr_w-1:0]   line_base;	// start of current line
	logic [vdma_pkg::addr_w-1:0]   burst_addr;
	logic [vdma_pkg::h_w-1:0]      pix_left;	// pixels of the line not yet requested
	logic [vdma_pkg::v_w-1:0]      lines_left;	// including the current line
	logic [vdma_pkg::credit_w-1:0] credits;

	logic [vdma_pkg::len_w:0]      max_beats;
	logic [vdma_pkg::len_w:0]      beats;
	logic [vdma_pkg::len_w:0]      beats_m1;
	logic                          line_end;	// this burst closes the line
	logic                          have_credit;
	logic                          handshake;
	logic [vdma_pkg::credit_w-1:0] credit_take;
	logic [vdma_pkg::addr_w-1:0]   next_line;

	// ----------------------------------------
	// burst sizing
	assign max_beats = {1'b0, param.arlen} + 1'b1;
	assign line_end  = {1'b0, pix_left} <=
		{{(vdma_pkg::h_w - vdma_pkg::len_w){1'b0}}, max_beats};
	assign beats     = line_end ? pix_left[vdma_pkg::len_w:0] : max_beats;	// remainder on last
	assign beats_m1  = beats - 1'b1;

	assign have_credit = {{(vdma_pkg::len_w + 1 - vdma_pkg::credit_w){1'b0}}, credits} >= beats;
	assign ar_valid    = active && have_credit;
	assign handshake   = ar_valid && ar_ready;
	assign credit_take = handshake ? beats[vdma_pkg::credit_w-1:0] : '0;

	assign next_line = line_base + {{(vdma_pkg::addr_w - vdma_pkg::stride_w){1'b0}}, param.stride};

	assign ar.addr = burst_addr;
	assign ar.len  = beats_m1[vdma_pkg::len_w-1:0];

	// ----------------------------------------
	// walk lines and bursts
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			active  <= 1'b0;
			done_q  <= 1'b0;
			credits <= vdma_pkg::credit_w'(vdma_pkg::fifo_depth);
		end else begin
			done_q  <= 1'b0;
			credits <= credits + credit_return - credit_take;
			if (frame_start) begin
				active  <= 1'b1;
				credits <= vdma_pkg::credit_w'(vdma_pkg::fifo_depth);	// buffer drained
			end else if (handshake && line_end && lines_left == 1) begin
				active <= 1'b0;	// last burst of the frame
				done_q <= 1'b1;
			end
		end
	end

	// position registers
	always_ff @(posedge aclk) begin
		if (frame_start) begin
			line_base  <= param.base;
			burst_addr <= param.base;
			pix_left   <= param.width;
			lines_left <= param.height;
		end else if (handshake) begin
			if (line_end) begin
				line_base  <= next_line;
				burst_addr <= next_line;
				pix_left   <= param.width;
				lines_left <= lines_left - 1'b1;
			end else begin
				burst_addr <= burst_addr +
					{{(vdma_pkg::addr_w - vdma_pkg::len_w - 3){1'b0}}, beats, 2'b00};
				pix_left   <= pix_left - {{(vdma_pkg::h_w - vdma_pkg::len_w - 1){1'b0}}, beats};
			end
		end
	end

	assign done = done_q;

endmodule

//--- hw/vdma_beat_fifo.sv
// show-ahead buffer with no full flag; the credit scheme upstream must prevent overflow
`timescale 1ns/1ns

module vdma_beat_fifo (
	input  logic              aclk,
	input  logic              aresetn,
	input  vdma_pkg::r_beat_t wr_data,
	input  logic              wr_en,
	output vdma_pkg::r_beat_t rd_data,
	input  logic              rd_en,
	output logic              empty,
	output logic              credit_return
);

	localparam int ptr_w = $clog2(vdma_pkg::fifo_depth);

	vdma_pkg::r_beat_t mem [vdma_pkg::fifo_depth];
	logic [ptr_w:0]    wr_ptr;	// extra bit tells wrap
	logic [ptr_w:0]    rd_ptr;
	logic              pop;
	logic              ret_q;

	assign empty = (wr_ptr == rd_ptr);
	assign pop   = rd_en && !empty;

	// ----------------------------------------
	// pointers
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			ret_q  <= 1'b0;
		end else begin
			ret_q <= pop;	// one credit per word out
			if (wr_en) wr_ptr <= wr_ptr + 1'b1;
			if (pop)   rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (wr_en) begin
			mem[wr_ptr[ptr_w-1:0]] <= wr_data;
		end
	end

	assign rd_data       = mem[rd_ptr[ptr_w-1:0]];	// head word, valid when not empty
	assign credit_return = ret_q;

endmodule

//--- hw/vdma_stream_framer.sv
// tags words in arrival order; assumes memory returns bursts in request order
`timescale 1ns/1ns

module vdma_stream_framer (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  vdma_pkg::frame_param_t param,
	input  logic                   frame_start,
	input  vdma_pkg::r_beat_t      word,
	input  logic                   word_avail,
	output logic                   word_pop,
	output vdma_pkg::pix_beat_t    pix,
	output logic                   pix_valid,
	input  logic                   pix_ready,
	output logic                   done
);

	logic                     active;
	logic                     done_q;
	logic [vdma_pkg::h_w-1:0] h_cnt;	// pixel within line
	logic [vdma_pkg::v_w-1:0] v_cnt;	// line within frame
	logic                     last_h;
	logic                     last_v;
	logic                     accept;

	assign last_h    = (h_cnt == param.width - 1'b1);
	assign last_v    = (v_cnt == param.height - 1'b1);
	assign pix_valid = active && word_avail;
	assign accept    = pix_valid && pix_ready;
	assign word_pop  = accept;

	// ----------------------------------------
	// counters
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			active <= 1'b0;
			done_q <= 1'b0;
			h_cnt  <= '0;
			v_cnt  <= '0;
		end else begin
			done_q <= 1'b0;
			if (frame_start) begin
				active <= 1'b1;
				h_cnt  <= '0;
				v_cnt  <= '0;
			end else if (accept) begin
				h_cnt <= last_h ? '0 : h_cnt + 1'b1;
				if (last_h) begin
					v_cnt <= v_cnt + 1'b1;
					if (last_v) begin
						active <= 1'b0;	// frame complete
						done_q <= 1'b1;
					end
				end
			end
		end
	end

	assign pix.data = word.data;
	assign pix.sof  = (h_cnt == 0) && (v_cnt == 0);
	assign pix.eol  = last_h;
	assign done     = done_q;

endmodule

//--- hw/vdma_read_top.sv
// single read ID and fixed AXI attributes are set by the interconnect; r_ready is always high
`timescale 1ns/1ns

module vdma_read_top (
	input  logic                         aclk,
	input  logic                         aresetn,
	// control
	input  logic                         ctl_enable,
	input  logic                         ctl_update,
	output logic                         ctl_busy,
	output logic [vdma_pkg::index_w-1:0] ctl_index,
	input  vdma_pkg::frame_param_t       frame_param,
	output vdma_pkg::frame_param_t       monitor_param,
	// read address
	output vdma_pkg::ar_req_t            ar,
	output logic                         ar_valid,
	input  logic                         ar_ready,
	// read data
	input  vdma_pkg::r_beat_t            r,
	input  logic                         r_valid,
	input  logic                         r_last,	// framer counts beats, burst ends not needed
	output logic                         r_ready,
	// pixel stream
	output vdma_pkg::pix_beat_t          pix,
	output logic                         pix_valid,
	input  logic                         pix_ready
);

	vdma_pkg::frame_param_t shadow_param;
	vdma_pkg::r_beat_t      fifo_word;
	logic                   frame_start;
	logic                   ag_done;
	logic                   fr_done;
	logic                   fifo_empty;
	logic                   fifo_pop;
	logic                   credit_return;

	// ----------------------------------------
	vdma_frame_ctrl u_frame_ctrl (
		.aclk, .aresetn, .ctl_enable, .ctl_update, .frame_param,
		.ctl_busy, .ctl_index, .shadow_param, .frame_start, .ag_done, .fr_done
	);

	vdma_addr_gen u_addr_gen (
		.aclk, .aresetn, .param(shadow_param), .frame_start,
		.ar, .ar_valid, .ar_ready, .credit_return, .done(ag_done)
	);

	// every beat is written, credits guarantee room
	vdma_beat_fifo u_beat_fifo (
		.aclk, .aresetn, .wr_data(r), .wr_en(r_valid),
		.rd_data(fifo_word), .rd_en(fifo_pop), .empty(fifo_empty), .credit_return
	);

	vdma_stream_framer u_stream_framer (
		.aclk, .aresetn, .param(shadow_param), .frame_start,
		.word(fifo_word), .word_avail(!fifo_empty), .word_pop(fifo_pop),
		.pix, .pix_valid, .pix_ready, .done(fr_done)
	);

	assign monitor_param = shadow_param;
	assign r_ready       = 1'b1;

endmodule

//--- sim/tb_clock_gen.sv
// 40 ns clock from time zero; reset low for the first two rising edges, released 2 ns after
`timescale 1ns/1ns

module tb_clock_gen (
	output logic aclk,
	output logic aresetn
);

	initial begin
		aclk    = 1'b0;
		aresetn = 1'b0;
		repeat (2) @(posedge aclk);
		#2 aresetn = 1'b1;	// off the edge like other inputs
	end

	always #20 aclk = ~aclk;

endmodule

//--- sim/tb_vdma_read.sv
// memory returns bursts in request order with data = byte address / 4; stops at the first error
`timescale 1ns/1ns

module tb_vdma_read;

	localparam int n_frames = 20;

	logic                         aclk, aresetn;
	logic                         ctl_enable, ctl_update, ctl_busy;
	logic [vdma_pkg::index_w-1:0] ctl_index;
	vdma_pkg::frame_param_t       frame_param, monitor_param;
	vdma_pkg::ar_req_t            ar;
	logic                         ar_valid, ar_ready;
	vdma_pkg::r_beat_t            r;
	logic                         r_valid, r_last, r_ready;
	vdma_pkg::pix_beat_t          pix;
	logic                         pix_valid, pix_ready;

	vdma_pkg::ar_req_t   ar_exp [$];	// model bursts
	vdma_pkg::pix_beat_t pix_exp [$];	// model pixels
	vdma_pkg::ar_req_t   burst_q [$];	// accepted and waiting for data
	int                  outstanding = 0;	// beats requested but not yet on the stream

	tb_clock_gen u_clk (.aclk, .aresetn);

	vdma_read_top UUT (.*);

	// ----------------------------------------
	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic check_ar(input vdma_pkg::ar_req_t got, input vdma_pkg::ar_req_t exp);
		if (got !== exp) begin
			$display("** Error @%0t ns: burst addr %h len %0d, expected addr %h len %0d",
				$time, got.addr, got.len, exp.addr, exp.len);
			stop_run();
		end
	endtask

	task automatic check_pix(input vdma_pkg::pix_beat_t got, input vdma_pkg::pix_beat_t exp);
		if (got !== exp) begin
			$display("** Error @%0t ns: pixel %h sof %b eol %b, expected %h sof %b eol %b",
				$time, got.data, got.sof, got.eol, exp.data, exp.sof, exp.eol);
			stop_run();
		end
	endtask

	task automatic check_param(input vdma_pkg::frame_param_t got,
		input vdma_pkg::frame_param_t exp);
		if (got !== exp) begin
			$display("** Error @%0t ns: shadow params %h, expected %h", $time, got, exp);
			stop_run();
		end
	endtask

	task automatic check_index(input logic [vdma_pkg::index_w-1:0] got,
		input logic [vdma_pkg::index_w-1:0] exp);
		if (got !== exp) begin
			$display("** Error @%0t ns: frame index %0d, expected %0d", $time, got, exp);
			stop_run();
		end
	endtask

	// expected bursts and pixels of one frame
	task automatic build_model(input vdma_pkg::frame_param_t p);
		vdma_pkg::ar_req_t           req;
		vdma_pkg::pix_beat_t         px;
		logic [vdma_pkg::addr_w-1:0] lb;
		int                          w;
		int                          n;
		w = p.width;
		for (int y = 0; y < p.height; y++) begin
			lb = p.base + y * p.stride;
			for (int x = 0; x < w; x += n) begin
				n = (w - x < p.arlen + 1) ? w - x : p.arlen + 1;	// short tail burst
				req.addr = lb + 4 * x;
				req.len  = n - 1;
				ar_exp.push_back(req);
			end
			for (int x = 0; x < w; x++) begin
				px.data = (lb + 4 * x) >> 2;
				px.sof  = (y == 0) && (x == 0);
				px.eol  = (x == w - 1);
				pix_exp.push_back(px);
			end
		end
	endtask

	// ----------------------------------------
	// monitor sampled on the edge
	always @(posedge aclk) begin
		if (aresetn) begin
			if (r_ready !== 1'b1) report_failure("r_ready was not held high");
			if (ar_valid && ar_ready) begin
				if (ar_exp.size() == 0) report_failure("read burst issued with none expected");
				check_ar(ar, ar_exp.pop_front());
				burst_q.push_back(ar);
				outstanding += ar.len + 1;
			end
			if (pix_valid && pix_ready) begin
				if (pix_exp.size() == 0) report_failure("pixel accepted with none expected");
				check_pix(pix, pix_exp.pop_front());
				outstanding--;
			end
			if (outstanding > vdma_pkg::fifo_depth)
				report_failure("more beats requested than the beat buffer holds");
		end
	end

	// ----------------------------------------
	initial begin : sequencer
		vdma_pkg::frame_param_t       drv_param [n_frames];
		bit                           upd [n_frames];
		vdma_pkg::frame_param_t       p, eff;
		vdma_pkg::ar_req_t            cur;
		logic [vdma_pkg::addr_w-1:0]  rd_addr;
		logic [vdma_pkg::index_w-1:0] exp_index;
		int                           beats_left, gap, total_pix;

		ctl_enable  = 1'b0;
		ctl_update  = 1'b0;
		frame_param = '0;
		ar_ready    = 1'b0;
		r           = '0;
		r_valid     = 1'b0;
		r_last      = 1'b0;
		pix_ready   = 1'b0;
		beats_left  = 0;
		gap         = 0;
		total_pix   = 0;
		void'($urandom(17242));

		for (int f = 0; f < n_frames; f++) begin
			p.width  = $urandom_range(1, 48);
			p.height = $urandom_range(1, 5);
			p.arlen  = ($urandom_range(0, 3) == 0) ? $urandom_range(0, 63) : $urandom_range(0, 7);
			p.stride = 4 * p.width + 4 * $urandom_range(0, 16);	// gap past line end
			p.base   = 4 * $urandom_range(0, 'h3fffff);
			drv_param[f] = p;
			upd[f] = (f == 0) || ($urandom_range(0, 2) != 0);	// first frame must load
			if (upd[f]) eff = p;
			total_pix += eff.width * eff.height;
		end

		fork
			begin : watchdog
				repeat (200 * total_pix + 1000) @(posedge aclk);
				report_failure($sformatf("the run timed out after %0d cycles",
					200 * total_pix + 1000));
			end
			forever begin	// memory responder and random sink
				@(posedge aclk);
				#2;
				ar_ready  = ($urandom_range(0, 3) != 0);
				pix_ready = ($urandom_range(0, 2) != 0);
				r_valid   = 1'b0;
				r_last    = 1'b0;
				if (beats_left == 0 && burst_q.size() != 0) begin
					cur        = burst_q.pop_front();
					rd_addr    = cur.addr;
					beats_left = cur.len + 1;
					gap        = $urandom_range(0, 6);	// read latency
				end
				if (beats_left != 0) begin
					if (gap != 0) begin
						gap--;
					end else if ($urandom_range(0, 3) != 0) begin
						r_valid    = 1'b1;
						r.data     = rd_addr >> 2;
						r_last     = (beats_left == 1);
						rd_addr    = rd_addr + 4;
						beats_left--;
					end
				end
			end
		join_none

		wait (aresetn === 1'b1);
		@(posedge aclk);
		#2;
		exp_index = '0;

		for (int f = 0; f < n_frames; f++) begin
			if (upd[f]) eff = drv_param[f];
			build_model(eff);
			ctl_enable  = 1'b1;
			ctl_update  = upd[f];
			frame_param = drv_param[f];
			@(posedge aclk);
			#2;
			ctl_enable = 1'b0;
			ctl_update = 1'b0;
			exp_index  = exp_index + 1'b1;
			if (ctl_busy !== 1'b1) report_failure("ctl_busy did not rise after enable");
			check_index(ctl_index, exp_index);
			check_param(monitor_param, eff);

			// enable while busy must be ignored
			ctl_enable  = 1'b1;
			ctl_update  = 1'b1;
			frame_param = ~eff;
			@(posedge aclk);
			#2;
			ctl_enable = 1'b0;
			ctl_update = 1'b0;
			check_index(ctl_index, exp_index);
			check_param(monitor_param, eff);

			do begin
				@(posedge aclk);
			end while (ctl_busy);
			#2;
			if (pix_exp.size() != 0 || ar_exp.size() != 0)
				report_failure("ctl_busy fell before the frame was fully delivered");
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- build.f
hw/vdma_pkg.sv
hw/vdma_frame_ctrl.sv
hw/vdma_addr_gen.sv
hw/vdma_beat_fifo.sv
hw/vdma_stream_framer.sv
hw/vdma_read_top.sv
sim/tb_clock_gen.sv
sim/tb_vdma_read.sv
